// ==== source/dwc_pkg.sv ====
/* Shared widths, burst codes and address helpers for the 32-to-64 bit AXI upsizer */
`default_nettype none

package dwc_pkg;

  localparam int unsigned addr_width     = 32;
  localparam int unsigned slv_data_width = 32;
  localparam int unsigned mst_data_width = 64;
  localparam int unsigned slv_strb_width = slv_data_width / 8;
  localparam int unsigned mst_strb_width = mst_data_width / 8;
  // log2 of the wide byte count and the size of an upsized beat
  localparam int unsigned mst_max_size   = 3;

  localparam int unsigned len_width  = 8;
  localparam int unsigned size_width = 3;

  localparam logic [1:0] burst_fixed = 2'b00;
  localparam logic [1:0] burst_incr  = 2'b01;

  typedef enum logic [1:0] {
    mode_idle,
    mode_pass,
    mode_upsize
  } mode_e;

  // Clear the address bits below the given beat size
  function automatic logic [addr_width-1:0] aligned_addr(
    input logic [addr_width-1:0] addr,
    input logic [size_width-1:0] size
  );
    logic [addr_width-1:0] mask;
    mask = '1;
    mask = mask << size;
    return addr & mask;
  endfunction

  // FIXED bursts keep their address and INCR bursts step by one beat
  function automatic logic [addr_width-1:0] next_beat_addr(
    input logic [addr_width-1:0] addr,
    input logic [size_width-1:0] size,
    input logic [1:0]            burst
  );
    logic [addr_width-1:0] step;
    step = addr_width'(1) << size;
    if (burst == burst_fixed) begin
      return addr;
    end
    return aligned_addr(addr, size) + step;
  endfunction

endpackage

`default_nettype wire

// ==== source/burst_planner.sv ====
/* Burst planner: picks pass or upsize mode for a new request
   and works out the wide burst length and beat size */
`timescale 1ns/1ps
`default_nettype none

module burst_planner import dwc_pkg::*; (
  input  logic [addr_width-1:0] req_addr_i,
  input  logic [len_width-1:0]  req_len_i,
  input  logic [size_width-1:0] req_size_i,
  input  logic [1:0]            req_burst_i,
  input  logic [3:0]            req_cache_i,
  output mode_e                 mode_o,
  output logic [len_width-1:0]  wide_len_o,
  output logic [size_width-1:0] wide_size_o
);

  logic                  upsize;
  logic [addr_width-1:0] last_addr;
  logic [addr_width-1:0] wide_first;
  logic [addr_width-1:0] wide_last;
  logic [addr_width-1:0] span;

  // Only modifiable multi-beat INCR bursts get merged
  assign upsize = (req_burst_i == burst_incr) && req_cache_i[1] && (req_len_i != '0);

  // Address of the final narrow beat
  assign last_addr = aligned_addr(req_addr_i, req_size_i)
                   + (addr_width'(req_len_i) << req_size_i);

  assign wide_first = aligned_addr(req_addr_i, size_width'(mst_max_size));
  assign wide_last  = aligned_addr(last_addr, size_width'(mst_max_size));
  assign span       = (wide_last - wide_first) >> mst_max_size;

  always_comb begin
    if (upsize) begin
      mode_o      = mode_upsize;
      wide_len_o  = span[len_width-1:0];
      wide_size_o = size_width'(mst_max_size);
    end else begin
      // FIXED, single-beat and non-modifiable bursts go out as sent
      mode_o      = mode_pass;
      wide_len_o  = req_len_i;
      wide_size_o = req_size_i;
    end
  end

endmodule

`default_nettype wire

// ==== source/write_upsizer.sv ====
/* Write path of the upsizer: registers the wide AW and packs
   narrow W beats into byte lanes of the wide W register */
`timescale 1ns/1ps
`default_nettype none

module write_upsizer import dwc_pkg::*; (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic [addr_width-1:0]     slv_aw_addr_i,
  input  logic [len_width-1:0]      slv_aw_len_i,
  input  logic [size_width-1:0]     slv_aw_size_i,
  input  logic [1:0]                slv_aw_burst_i,
  input  logic [3:0]                slv_aw_cache_i,
  input  logic                      slv_aw_valid_i,
  output logic                      slv_aw_ready_o,
  input  logic [slv_data_width-1:0] slv_w_data_i,
  input  logic [slv_strb_width-1:0] slv_w_strb_i,
  input  logic                      slv_w_last_i,
  input  logic                      slv_w_valid_i,
  output logic                      slv_w_ready_o,
  output logic [addr_width-1:0]     mst_aw_addr_o,
  output logic [len_width-1:0]      mst_aw_len_o,
  output logic [size_width-1:0]     mst_aw_size_o,
  output logic [1:0]                mst_aw_burst_o,
  output logic [3:0]                mst_aw_cache_o,
  output logic                      mst_aw_valid_o,
  input  logic                      mst_aw_ready_i,
  output logic [mst_data_width-1:0] mst_w_data_o,
  output logic [mst_strb_width-1:0] mst_w_strb_o,
  output logic                      mst_w_last_o,
  output logic                      mst_w_valid_o,
  input  logic                      mst_w_ready_i
);

  mode_e                     state_q;
  mode_e                     plan_mode;
  logic [len_width-1:0]      plan_len;
  logic [size_width-1:0]     plan_size;
  logic [addr_width-1:0]     addr_q;
  logic [addr_width-1:0]     next_addr;
  logic [len_width-1:0]      beats_q;
  logic [size_width-1:0]     size_q;
  logic                      aw_valid_q;
  logic                      w_valid_q;
  logic                      w_last_q;
  logic [mst_data_width-1:0] w_data_q;
  logic [mst_data_width-1:0] w_data_d;
  logic [mst_strb_width-1:0] w_strb_q;
  logic [mst_strb_width-1:0] w_strb_d;
  logic                      aw_acc;
  logic                      w_acc;
  logic                      emit;

  burst_planner i_planner (
    .req_addr_i  (slv_aw_addr_i),
    .req_len_i   (slv_aw_len_i),
    .req_size_i  (slv_aw_size_i),
    .req_burst_i (slv_aw_burst_i),
    .req_cache_i (slv_aw_cache_i),
    .mode_o      (plan_mode),
    .wide_len_o  (plan_len),
    .wide_size_o (plan_size)
  );

  assign slv_aw_ready_o = (state_q == mode_idle);
  assign aw_acc         = slv_aw_valid_i && slv_aw_ready_o;

  // No new narrow beat once the final wide beat sits in the register
  assign slv_w_ready_o = (state_q != mode_idle) && !aw_valid_q
                       && (!w_valid_q || mst_w_ready_i) && !(w_valid_q && w_last_q);
  assign w_acc         = slv_w_valid_i && slv_w_ready_o;

  assign mst_aw_valid_o = aw_valid_q;
  assign mst_w_data_o   = w_data_q;
  assign mst_w_strb_o   = w_strb_q;
  assign mst_w_last_o   = w_last_q;
  assign mst_w_valid_o  = w_valid_q;

  always_comb begin
    int unsigned lane;
    lane = (int'(addr_q[mst_max_size-1:0]) / slv_strb_width) * slv_strb_width;
    w_data_d = w_data_q;
    // A word that was emitted starts over with no strobes
    w_strb_d = w_valid_q ? '0 : w_strb_q;
    for (int b = 0; b < slv_strb_width; b++) begin
      w_data_d[8*(lane+b) +: 8] = slv_w_data_i[8*b +: 8];
      w_strb_d[lane+b]          = slv_w_strb_i[b];
    end
    next_addr = next_beat_addr(addr_q, size_q, mst_aw_burst_o);
    emit = (state_q != mode_upsize) || (beats_q == '0)
         || (aligned_addr(next_addr, size_width'(mst_max_size))
             != aligned_addr(addr_q, size_width'(mst_max_size)));
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= mode_idle;
      aw_valid_q <= 1'b0;
      w_valid_q  <= 1'b0;
      w_last_q   <= 1'b0;
      w_strb_q   <= '0;
    end else begin
      if (aw_acc) begin
        state_q    <= plan_mode;
        aw_valid_q <= 1'b1;
      end else if (mst_aw_ready_i) begin
        aw_valid_q <= 1'b0;
      end
      if (w_acc) begin
        w_strb_q  <= w_strb_d;
        w_last_q  <= slv_w_last_i;
        w_valid_q <= emit;
      end else if (w_valid_q && mst_w_ready_i) begin
        w_valid_q <= 1'b0;
        w_strb_q  <= '0;
        // Burst is done once the master takes the last wide beat
        if (w_last_q) begin
          state_q <= mode_idle;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (aw_acc) begin
      addr_q         <= slv_aw_addr_i;
      beats_q        <= slv_aw_len_i;
      size_q         <= slv_aw_size_i;
      mst_aw_addr_o  <= slv_aw_addr_i;
      mst_aw_len_o   <= plan_len;
      mst_aw_size_o  <= plan_size;
      mst_aw_burst_o <= slv_aw_burst_i;
      mst_aw_cache_o <= slv_aw_cache_i;
    end else if (w_acc) begin
      addr_q  <= next_addr;
      beats_q <= beats_q - len_width'(1);
    end
    if (w_acc) begin
      w_data_q <= w_data_d;
    end
  end

  // Wide W must wait for the wide AW handshake
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(mst_w_valid_o) |-> !mst_aw_valid_o);

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    mst_w_valid_o && !mst_w_ready_i |=> mst_w_valid_o && $stable(mst_w_data_o)
      && $stable(mst_w_strb_o) && $stable(mst_w_last_o));

endmodule

`default_nettype wire

// ==== source/read_upsizer.sv ====
/* Read path of the upsizer: registers the wide AR and steers
   bytes of each wide R beat onto the narrow R port */
`timescale 1ns/1ps
`default_nettype none

module read_upsizer import dwc_pkg::*; (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic [addr_width-1:0]     slv_ar_addr_i,
  input  logic [len_width-1:0]      slv_ar_len_i,
  input  logic [size_width-1:0]     slv_ar_size_i,
  input  logic [1:0]                slv_ar_burst_i,
  input  logic [3:0]                slv_ar_cache_i,
  input  logic                      slv_ar_valid_i,
  output logic                      slv_ar_ready_o,
  output logic [slv_data_width-1:0] slv_r_data_o,
  output logic [1:0]                slv_r_resp_o,
  output logic                      slv_r_last_o,
  output logic                      slv_r_valid_o,
  input  logic                      slv_r_ready_i,
  output logic [addr_width-1:0]     mst_ar_addr_o,
  output logic [len_width-1:0]      mst_ar_len_o,
  output logic [size_width-1:0]     mst_ar_size_o,
  output logic [1:0]                mst_ar_burst_o,
  output logic [3:0]                mst_ar_cache_o,
  output logic                      mst_ar_valid_o,
  input  logic                      mst_ar_ready_i,
  input  logic [mst_data_width-1:0] mst_r_data_i,
  input  logic [1:0]                mst_r_resp_i,
  input  logic                      mst_r_last_i,
  input  logic                      mst_r_valid_i,
  output logic                      mst_r_ready_o
);

  mode_e                 state_q;
  mode_e                 plan_mode;
  logic [len_width-1:0]  plan_len;
  logic [size_width-1:0] plan_size;
  logic [addr_width-1:0] addr_q;
  logic [addr_width-1:0] next_addr;
  logic [len_width-1:0]  beats_q;
  logic [size_width-1:0] size_q;
  logic                  ar_valid_q;
  logic                  ar_acc;
  logic                  active;
  logic                  r_acc;
  logic                  word_done;

  burst_planner i_planner (
    .req_addr_i  (slv_ar_addr_i),
    .req_len_i   (slv_ar_len_i),
    .req_size_i  (slv_ar_size_i),
    .req_burst_i (slv_ar_burst_i),
    .req_cache_i (slv_ar_cache_i),
    .mode_o      (plan_mode),
    .wide_len_o  (plan_len),
    .wide_size_o (plan_size)
  );

  assign slv_ar_ready_o = (state_q == mode_idle);
  assign ar_acc         = slv_ar_valid_i && slv_ar_ready_o;
  assign mst_ar_valid_o = ar_valid_q;

  // R only flows once the wide AR has gone out
  assign active        = (state_q != mode_idle) && !ar_valid_q;
  assign slv_r_valid_o = active && mst_r_valid_i;
  assign slv_r_resp_o  = mst_r_resp_i;
  assign slv_r_last_o  = mst_r_last_i && (beats_q == '0);
  assign r_acc         = slv_r_valid_o && slv_r_ready_i;

  always_comb begin
    int unsigned lane;
    lane = (int'(addr_q[mst_max_size-1:0]) / slv_strb_width) * slv_strb_width;
    for (int b = 0; b < slv_strb_width; b++) begin
      slv_r_data_o[8*b +: 8] = mst_r_data_i[8*(lane+b) +: 8];
    end
    next_addr = next_beat_addr(addr_q, size_q, mst_ar_burst_o);
    word_done = (beats_q == '0)
              || (aligned_addr(next_addr, size_width'(mst_max_size))
                  != aligned_addr(addr_q, size_width'(mst_max_size)));
  end

  // In upsize mode the wide beat is held until its last narrow lane is used
  assign mst_r_ready_o = active && slv_r_ready_i
                       && ((state_q != mode_upsize) || word_done);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= mode_idle;
      ar_valid_q <= 1'b0;
    end else begin
      if (ar_acc) begin
        state_q    <= plan_mode;
        ar_valid_q <= 1'b1;
      end else if (mst_ar_ready_i) begin
        ar_valid_q <= 1'b0;
      end
      if (r_acc && (beats_q == '0)) begin
        state_q <= mode_idle;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (ar_acc) begin
      addr_q         <= slv_ar_addr_i;
      beats_q        <= slv_ar_len_i;
      size_q         <= slv_ar_size_i;
      mst_ar_addr_o  <= slv_ar_addr_i;
      mst_ar_len_o   <= plan_len;
      mst_ar_size_o  <= plan_size;
      mst_ar_burst_o <= slv_ar_burst_i;
      mst_ar_cache_o <= slv_ar_cache_i;
    end else if (r_acc) begin
      addr_q  <= next_addr;
      beats_q <= beats_q - len_width'(1);
    end
  end

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    mst_ar_valid_o |-> !slv_r_valid_o);

endmodule

`default_nettype wire

// ==== source/axi_dw_upsizer_top.sv ====
/* AXI data-width upsizer, 32-bit slave port to 64-bit master port */
`timescale 1ns/1ps
`default_nettype none

module axi_dw_upsizer_top import dwc_pkg::*; (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  // Narrow slave side
  input  logic [addr_width-1:0]     slv_aw_addr_i,
  input  logic [len_width-1:0]      slv_aw_len_i,
  input  logic [size_width-1:0]     slv_aw_size_i,
  input  logic [1:0]                slv_aw_burst_i,
  input  logic [3:0]                slv_aw_cache_i,
  input  logic                      slv_aw_valid_i,
  output logic                      slv_aw_ready_o,
  input  logic [slv_data_width-1:0] slv_w_data_i,
  input  logic [slv_strb_width-1:0] slv_w_strb_i,
  input  logic                      slv_w_last_i,
  input  logic                      slv_w_valid_i,
  output logic                      slv_w_ready_o,
  output logic [1:0]                slv_b_resp_o,
  output logic                      slv_b_valid_o,
  input  logic                      slv_b_ready_i,
  input  logic [addr_width-1:0]     slv_ar_addr_i,
  input  logic [len_width-1:0]      slv_ar_len_i,
  input  logic [size_width-1:0]     slv_ar_size_i,
  input  logic [1:0]                slv_ar_burst_i,
  input  logic [3:0]                slv_ar_cache_i,
  input  logic                      slv_ar_valid_i,
  output logic                      slv_ar_ready_o,
  output logic [slv_data_width-1:0] slv_r_data_o,
  output logic [1:0]                slv_r_resp_o,
  output logic                      slv_r_last_o,
  output logic                      slv_r_valid_o,
  input  logic                      slv_r_ready_i,
  // Wide master side
  output logic [addr_width-1:0]     mst_aw_addr_o,
  output logic [len_width-1:0]      mst_aw_len_o,
  output logic [size_width-1:0]     mst_aw_size_o,
  output logic [1:0]                mst_aw_burst_o,
  output logic [3:0]                mst_aw_cache_o,
  output logic                      mst_aw_valid_o,
  input  logic                      mst_aw_ready_i,
  output logic [mst_data_width-1:0] mst_w_data_o,
  output logic [mst_strb_width-1:0] mst_w_strb_o,
  output logic                      mst_w_last_o,
  output logic                      mst_w_valid_o,
  input  logic                      mst_w_ready_i,
  input  logic [1:0]                mst_b_resp_i,
  input  logic                      mst_b_valid_i,
  output logic                      mst_b_ready_o,
  output logic [addr_width-1:0]     mst_ar_addr_o,
  output logic [len_width-1:0]      mst_ar_len_o,
  output logic [size_width-1:0]     mst_ar_size_o,
  output logic [1:0]                mst_ar_burst_o,
  output logic [3:0]                mst_ar_cache_o,
  output logic                      mst_ar_valid_o,
  input  logic                      mst_ar_ready_i,
  input  logic [mst_data_width-1:0] mst_r_data_i,
  input  logic [1:0]                mst_r_resp_i,
  input  logic                      mst_r_last_i,
  input  logic                      mst_r_valid_i,
  output logic                      mst_r_ready_o
);

  // Port names match one to one
  write_upsizer i_write_upsizer (.*);

  read_upsizer i_read_upsizer (.*);

  // B needs no conversion and passes straight through
  assign slv_b_resp_o  = mst_b_resp_i;
  assign slv_b_valid_o = mst_b_valid_i;
  assign mst_b_ready_o = slv_b_ready_i;

endmodule

`default_nettype wire

// ==== tb/wide_mem_model.sv ====
/* Behavioral 64-bit AXI memory on the wide master port,
   with per-channel stall inputs and a log of accepted addresses */
`timescale 1ns/1ps
`default_nettype none

module wide_mem_model import dwc_pkg::*; (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  // Bits 0 to 3 hold off AW ready, W ready, AR ready and R valid
  input  logic [3:0]                stall_i,
  input  logic [addr_width-1:0]     aw_addr_i,
  input  logic [len_width-1:0]      aw_len_i,
  input  logic [size_width-1:0]     aw_size_i,
  input  logic [1:0]                aw_burst_i,
  input  logic                      aw_valid_i,
  output logic                      aw_ready_o,
  input  logic [mst_data_width-1:0] w_data_i,
  input  logic [mst_strb_width-1:0] w_strb_i,
  input  logic                      w_last_i,
  input  logic                      w_valid_i,
  output logic                      w_ready_o,
  output logic [1:0]                b_resp_o,
  output logic                      b_valid_o,
  input  logic                      b_ready_i,
  input  logic [addr_width-1:0]     ar_addr_i,
  input  logic [len_width-1:0]      ar_len_i,
  input  logic [size_width-1:0]     ar_size_i,
  input  logic [1:0]                ar_burst_i,
  input  logic                      ar_valid_i,
  output logic                      ar_ready_o,
  output logic [mst_data_width-1:0] r_data_o,
  output logic [1:0]                r_resp_o,
  output logic                      r_last_o,
  output logic                      r_valid_o,
  input  logic                      r_ready_i
);

  logic [7:0]            mem [0:4095];
  logic                  w_busy_q, b_valid_q, r_busy_q, r_valid_q;
  logic [addr_width-1:0] w_addr_q, r_addr_q;
  logic [size_width-1:0] w_size_q, r_size_q;
  logic [1:0]            w_burst_q, r_burst_q;
  logic [len_width-1:0]  r_cnt_q;
  // Log of the most recent address of each kind
  int unsigned           aw_count, ar_count;
  logic [len_width-1:0]  aw_len_log, ar_len_log;
  logic [size_width-1:0] aw_size_log, ar_size_log;

  // Byte lane of the 64-bit word that holds the address
  function automatic logic [11:0] byte_index(input logic [addr_width-1:0] addr, input int lane);
    return 12'({addr[11:3], 3'b000} + lane);
  endfunction

  function automatic logic [addr_width-1:0] step_addr(input logic [addr_width-1:0] addr,
      input logic [size_width-1:0] size, input logic [1:0] burst);
    logic [addr_width-1:0] bytes;
    bytes = addr_width'(1) << size;
    if (burst == burst_fixed) begin
      return addr;
    end
    return (addr & ~(bytes - 1)) + bytes;
  endfunction

  assign aw_ready_o = !w_busy_q && !stall_i[0];
  assign w_ready_o  = w_busy_q && !b_valid_q && !stall_i[1];
  assign b_resp_o   = 2'b00;
  assign b_valid_o  = b_valid_q;
  assign ar_ready_o = !r_busy_q && !stall_i[2];
  assign r_valid_o  = r_valid_q;
  assign r_resp_o   = 2'b00;
  assign r_last_o   = (r_cnt_q == '0);

  always_comb begin
    for (int i = 0; i < mst_strb_width; i++) begin
      r_data_o[8*i +: 8] = mem[byte_index(r_addr_q, i)];
    end
  end

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      w_busy_q  <= 1'b0;
      b_valid_q <= 1'b0;
      r_busy_q  <= 1'b0;
      r_valid_q <= 1'b0;
      r_cnt_q   <= '0;
      aw_count  <= 0;
      ar_count  <= 0;
      // Fill pattern mixes every address bit
      for (int i = 0; i < 4096; i++) begin
        mem[i] <= 8'(i) ^ 8'(i >> 8);
      end
    end else begin
      if (aw_valid_i && aw_ready_o) begin
        w_busy_q    <= 1'b1;
        w_addr_q    <= aw_addr_i;
        w_size_q    <= aw_size_i;
        w_burst_q   <= aw_burst_i;
        aw_len_log  <= aw_len_i;
        aw_size_log <= aw_size_i;
        aw_count    <= aw_count + 1;
      end
      if (w_valid_i && w_ready_o) begin
        for (int i = 0; i < mst_strb_width; i++) begin
          if (w_strb_i[i]) begin
            mem[byte_index(w_addr_q, i)] <= w_data_i[8*i +: 8];
          end
        end
        w_addr_q <= step_addr(w_addr_q, w_size_q, w_burst_q);
        if (w_last_i) begin
          b_valid_q <= 1'b1;
        end
      end
      if (b_valid_q && b_ready_i) begin
        b_valid_q <= 1'b0;
        w_busy_q  <= 1'b0;
      end
      if (ar_valid_i && ar_ready_o) begin
        r_busy_q    <= 1'b1;
        r_addr_q    <= ar_addr_i;
        r_size_q    <= ar_size_i;
        r_burst_q   <= ar_burst_i;
        r_cnt_q     <= ar_len_i;
        ar_len_log  <= ar_len_i;
        ar_size_log <= ar_size_i;
        ar_count    <= ar_count + 1;
      end
      // Once raised, R valid holds until the beat is taken
      if (r_busy_q && !r_valid_q && !stall_i[3]) begin
        r_valid_q <= 1'b1;
      end
      if (r_valid_q && r_ready_i) begin
        r_valid_q <= 1'b0;
        r_addr_q  <= step_addr(r_addr_q, r_size_q, r_burst_q);
        r_cnt_q   <= r_cnt_q - 1'b1;
        if (r_cnt_q == '0) begin
          r_busy_q <= 1'b0;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== tb/upsizer_tb.sv ====
/* Testbench for the 32-to-64 bit AXI upsizer, directed
   write and read bursts against a wide memory model */
`timescale 1ns/1ps
`default_nettype none

module upsizer_tb import dwc_pkg::*; ();

  localparam int unsigned num_tests = 5;

  logic clk_i, rst_ni;
  logic [addr_width-1:0] slv_aw_addr_i, slv_ar_addr_i, mst_aw_addr_o, mst_ar_addr_o;
  logic [len_width-1:0] slv_aw_len_i, slv_ar_len_i, mst_aw_len_o, mst_ar_len_o;
  logic [size_width-1:0] slv_aw_size_i, slv_ar_size_i, mst_aw_size_o, mst_ar_size_o;
  logic [1:0] slv_aw_burst_i, slv_ar_burst_i, mst_aw_burst_o, mst_ar_burst_o;
  logic [3:0] slv_aw_cache_i, slv_ar_cache_i, mst_aw_cache_o, mst_ar_cache_o;
  logic slv_aw_valid_i, slv_aw_ready_o, slv_ar_valid_i, slv_ar_ready_o;
  logic mst_aw_valid_o, mst_aw_ready_i, mst_ar_valid_o, mst_ar_ready_i;
  logic [slv_data_width-1:0] slv_w_data_i, slv_r_data_o;
  logic [slv_strb_width-1:0] slv_w_strb_i;
  logic slv_w_last_i, slv_w_valid_i, slv_w_ready_o;
  logic [1:0] slv_b_resp_o, slv_r_resp_o, mst_b_resp_i, mst_r_resp_i;
  logic slv_b_valid_o, slv_b_ready_i, mst_b_valid_i, mst_b_ready_o;
  logic slv_r_last_o, slv_r_valid_o, slv_r_ready_i;
  logic [mst_data_width-1:0] mst_w_data_o, mst_r_data_i;
  logic [mst_strb_width-1:0] mst_w_strb_o;
  logic mst_w_last_o, mst_w_valid_o, mst_w_ready_i;
  logic mst_r_last_i, mst_r_valid_i, mst_r_ready_o;

  logic [15:0] lfsr_q = 16'd90;
  logic [3:0] stall_q;
  logic stall_en, r_stall, r_ready_en;
  logic [31:0] wr_q[$];
  logic [31:0] rd_q[$];
  logic rd_last_q[$];
  int unsigned err_count, tests_passed, tests_failed;

  axi_dw_upsizer_top i_dut (.*);

  wide_mem_model i_mem (
    .clk_i, .rst_ni, .stall_i (stall_q),
    .aw_addr_i (mst_aw_addr_o), .aw_len_i (mst_aw_len_o), .aw_size_i (mst_aw_size_o),
    .aw_burst_i (mst_aw_burst_o), .aw_valid_i (mst_aw_valid_o), .aw_ready_o (mst_aw_ready_i),
    .w_data_i (mst_w_data_o), .w_strb_i (mst_w_strb_o), .w_last_i (mst_w_last_o),
    .w_valid_i (mst_w_valid_o), .w_ready_o (mst_w_ready_i),
    .b_resp_o (mst_b_resp_i), .b_valid_o (mst_b_valid_i), .b_ready_i (mst_b_ready_o),
    .ar_addr_i (mst_ar_addr_o), .ar_len_i (mst_ar_len_o), .ar_size_i (mst_ar_size_o),
    .ar_burst_i (mst_ar_burst_o), .ar_valid_i (mst_ar_valid_o), .ar_ready_o (mst_ar_ready_i),
    .r_data_o (mst_r_data_i), .r_resp_o (mst_r_resp_i), .r_last_o (mst_r_last_i),
    .r_valid_o (mst_r_valid_i), .r_ready_i (mst_r_ready_o)
  );

  // Narrow R ready is gated by the random stall when back-pressure is on
  assign slv_r_ready_i = r_ready_en && !r_stall;

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // Galois LFSR stepped once per random bit
  function automatic logic rand_bit();
    logic out;
    out = lfsr_q[0];
    lfsr_q = lfsr_q >> 1;
    if (out) begin
      lfsr_q = lfsr_q ^ 16'hB400;
    end
    return out;
  endfunction

  function automatic logic [31:0] rand_word();
    logic [31:0] word;
    word = '0;
    for (int i = 0; i < 32; i++) begin
      word = {word[30:0], rand_bit()};
    end
    return word;
  endfunction

  initial begin
    forever begin
      @(posedge clk_i);
      #1;
      if (stall_en) begin
        for (int i = 0; i < 4; i++) begin
          stall_q[i] = rand_bit();
        end
        r_stall = rand_bit();
      end else begin
        stall_q = '0;
        r_stall = 1'b0;
      end
    end
  end

  task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp) else begin
      $display("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp);
      err_count++;
    end
  endtask

  task automatic report_test(input string name, input int unsigned errs_at_start);
    if (err_count == errs_at_start) begin
      tests_passed++;
      $display("Test %s: passed", name);
    end else begin
      tests_failed++;
      $display("Test %s: failed with %0d errors", name, err_count - errs_at_start);
    end
  endtask

  // Sends wr_q as one write burst and waits for the B response
  task automatic write_burst(input logic [31:0] addr, input logic [7:0] len,
      input logic [2:0] size, input logic [1:0] burst, input logic [3:0] cache);
    logic done;
    logic [1:0] resp;
    int unsigned aw_before;
    aw_before = i_mem.aw_count;
    slv_aw_addr_i = addr;
    slv_aw_len_i = len;
    slv_aw_size_i = size;
    slv_aw_burst_i = burst;
    slv_aw_cache_i = cache;
    slv_aw_valid_i = 1'b1;
    done = 1'b0;
    while (!done) begin
      @(negedge clk_i);
      done = slv_aw_ready_o;
      @(posedge clk_i);
      #1;
    end
    slv_aw_valid_i = 1'b0;
    for (int beat = 0; beat <= int'(len); beat++) begin
      slv_w_data_i = wr_q[beat];
      slv_w_strb_i = '1;
      slv_w_last_i = (beat == int'(len));
      slv_w_valid_i = 1'b1;
      done = 1'b0;
      while (!done) begin
        @(negedge clk_i);
        done = slv_w_ready_o;
        @(posedge clk_i);
        #1;
      end
    end
    slv_w_valid_i = 1'b0;
    slv_w_last_i = 1'b0;
    slv_b_ready_i = 1'b1;
    done = 1'b0;
    while (!done) begin
      @(negedge clk_i);
      done = slv_b_valid_o;
      resp = slv_b_resp_o;
      @(posedge clk_i);
      #1;
    end
    slv_b_ready_i = 1'b0;
    check_val("slv_b_resp_o", resp, 2'b00);
    // Burst type and cache attributes go out unchanged
    check_val("mst_aw_burst_o", mst_aw_burst_o, burst);
    check_val("mst_aw_cache_o", mst_aw_cache_o, cache);
    assert (i_mem.aw_count == aw_before + 1) else begin
      $display("Memory did not see exactly one write address for the burst at 0x%0h", addr);
      err_count++;
    end
  endtask

  // Reads one burst into rd_q and rd_last_q
  task automatic read_burst(input logic [31:0] addr, input logic [7:0] len,
      input logic [2:0] size, input logic [1:0] burst, input logic [3:0] cache);
    logic done;
    slv_ar_addr_i = addr;
    slv_ar_len_i = len;
    slv_ar_size_i = size;
    slv_ar_burst_i = burst;
    slv_ar_cache_i = cache;
    slv_ar_valid_i = 1'b1;
    done = 1'b0;
    while (!done) begin
      @(negedge clk_i);
      done = slv_ar_ready_o;
      @(posedge clk_i);
      #1;
    end
    slv_ar_valid_i = 1'b0;
    rd_q.delete();
    rd_last_q.delete();
    r_ready_en = 1'b1;
    while (rd_q.size() <= int'(len)) begin
      @(negedge clk_i);
      if (slv_r_valid_o && slv_r_ready_i) begin
        rd_q.push_back(slv_r_data_o);
        rd_last_q.push_back(slv_r_last_o);
        check_val("slv_r_resp_o", slv_r_resp_o, 2'b00);
      end
      @(posedge clk_i);
      #1;
    end
    r_ready_en = 1'b0;
    check_val("mst_ar_burst_o", mst_ar_burst_o, burst);
    check_val("mst_ar_cache_o", mst_ar_cache_o, cache);
  endtask

  task automatic check_readback(input int unsigned len);
    for (int unsigned i = 0; i <= len; i++) begin
      check_val("slv_r_data_o", rd_q[i], wr_q[i]);
      check_val("slv_r_last_o", rd_last_q[i], i == len);
    end
  endtask

  task automatic test_single_beat();
    int unsigned errs;
    errs = err_count;
    wr_q = '{32'hA5C3_1E0F};
    write_burst(32'h10, 8'd0, 3'd2, burst_incr, 4'h2);
    check_val("mst_aw_len_o", i_mem.aw_len_log, 0);
    check_val("mst_aw_size_o", i_mem.aw_size_log, 2);
    read_burst(32'h10, 8'd0, 3'd2, burst_incr, 4'h2);
    check_readback(0);
    report_test("single_beat", errs);
  endtask

  task automatic test_aligned_incr();
    int unsigned errs;
    errs = err_count;
    wr_q = '{32'h1111_0001, 32'h2222_0002, 32'h3333_0003, 32'h4444_0004};
    write_burst(32'h100, 8'd3, 3'd2, burst_incr, 4'h2);
    // Four narrow beats from 0x100 fill two wide words
    check_val("mst_aw_len_o", i_mem.aw_len_log, 1);
    check_val("mst_aw_size_o", i_mem.aw_size_log, 3);
    read_burst(32'h100, 8'd3, 3'd2, burst_incr, 4'h2);
    check_val("mst_ar_len_o", i_mem.ar_len_log, 1);
    check_readback(3);
    report_test("aligned_incr", errs);
  endtask

  task automatic test_unaligned_incr();
    int unsigned errs;
    errs = err_count;
    wr_q = '{32'hDEAD_BEEF, 32'h0BAD_F00D, 32'hC0FF_EE42};
    write_burst(32'h204, 8'd2, 3'd2, burst_incr, 4'h2);
    check_val("mst_aw_len_o", i_mem.aw_len_log, 1);
    for (int i = 0; i < 12; i++) begin
      check_val($sformatf("mem[0x%0h]", 32'h204 + i), i_mem.mem[12'h204 + i],
                wr_q[i / 4][8 * (i % 4) +: 8]);
    end
    read_burst(32'h204, 8'd2, 3'd2, burst_incr, 4'h2);
    check_readback(2);
    report_test("unaligned_incr", errs);
  endtask

  task automatic test_pass_through();
    int unsigned errs;
    errs = err_count;
    wr_q = '{32'h0101_0101, 32'h0202_0202, 32'h7E57_A11E};
    write_burst(32'h300, 8'd2, 3'd2, burst_fixed, 4'h2);
    check_val("mst_aw_len_o", i_mem.aw_len_log, 2);
    check_val("mst_aw_size_o", i_mem.aw_size_log, 2);
    // Every FIXED beat hits the same word, so the last one remains
    for (int i = 0; i < 4; i++) begin
      check_val($sformatf("mem[0x%0h]", 32'h300 + i), i_mem.mem[12'h300 + i],
                wr_q[2][8 * i +: 8]);
    end
    wr_q = '{32'h5A5A_0F0F, 32'h6B6B_1E1E, 32'h7C7C_2D2D};
    write_burst(32'h320, 8'd2, 3'd2, burst_incr, 4'h0);
    check_val("mst_aw_len_o", i_mem.aw_len_log, 2);
    check_val("mst_aw_size_o", i_mem.aw_size_log, 2);
    read_burst(32'h320, 8'd2, 3'd2, burst_incr, 4'h0);
    check_val("mst_ar_len_o", i_mem.ar_len_log, 2);
    check_val("mst_ar_size_o", i_mem.ar_size_log, 2);
    check_readback(2);
    report_test("pass_through", errs);
  endtask

  task automatic test_back_pressure();
    int unsigned errs;
    errs = err_count;
    wr_q.delete();
    for (int i = 0; i < 8; i++) begin
      wr_q.push_back(rand_word());
    end
    @(negedge clk_i);
    stall_en = 1'b1;
    @(posedge clk_i);
    #1;
    write_burst(32'h400, 8'd7, 3'd2, burst_incr, 4'h2);
    check_val("mst_aw_len_o", i_mem.aw_len_log, 3);
    read_burst(32'h400, 8'd7, 3'd2, burst_incr, 4'h2);
    check_readback(7);
    @(negedge clk_i);
    stall_en = 1'b0;
    @(posedge clk_i);
    #1;
    report_test("back_pressure", errs);
  endtask

  initial begin
    rst_ni = 1'b0;
    {slv_aw_addr_i, slv_aw_len_i, slv_aw_size_i, slv_aw_burst_i, slv_aw_cache_i} = '0;
    {slv_ar_addr_i, slv_ar_len_i, slv_ar_size_i, slv_ar_burst_i, slv_ar_cache_i} = '0;
    slv_aw_valid_i = 1'b0;
    slv_ar_valid_i = 1'b0;
    slv_w_data_i = '0;
    slv_w_strb_i = '0;
    slv_w_last_i = 1'b0;
    slv_w_valid_i = 1'b0;
    slv_b_ready_i = 1'b0;
    r_ready_en = 1'b0;
    r_stall = 1'b0;
    stall_en = 1'b0;
    stall_q = '0;
    err_count = 0;
    tests_passed = 0;
    tests_failed = 0;
    repeat (2) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    test_single_beat();
    test_aligned_incr();
    test_unaligned_incr();
    test_pass_through();
    test_back_pressure();
    $display("Tests run %0d, passed %0d, failed %0d, failed checks %0d",
             num_tests, tests_passed, tests_failed, err_count);
    if (tests_failed == 0 && err_count == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  // Watchdog scaled by the number of tests
  initial begin
    repeat (num_tests * 200) @(posedge clk_i);
    $display("Watchdog expired after %0d cycles, a handshake never completed", num_tests * 200);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== dw_upsizer.f ====
source/dwc_pkg.sv
source/burst_planner.sv
source/write_upsizer.sv
source/read_upsizer.sv
source/axi_dw_upsizer_top.sv
tb/wide_mem_model.sv
tb/upsizer_tb.sv
